// File: common/iq_defs.svh
`ifndef IQ_DEFS_SVH
`define IQ_DEFS_SVH

// dispatch slots, issue lanes and writeback lanes
`define IQ_DISPATCH_WIDTH 2

`define IQ_SIZE 8

// physical register tag width
`define IQ_TAG_BITS 6

`endif

// File: common/iq_pkg.sv
`include "iq_defs.svh"

package iq_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5, // shift amount from op2[4:0]
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7  // signed compare
  } alu_cmd_t;

  // one operand word, read as a tag while waiting and as data once ready
  typedef union packed {
    logic [31:0] data;
    struct packed {
      logic [31-`IQ_TAG_BITS:0] pad;
      logic [`IQ_TAG_BITS-1:0]  phys;
    } tag;
  } operand_t;

endpackage

// File: issue_queue/issue_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_defs.svh"

module issue_select #(
  localparam int IDX_BITS = $clog2(`IQ_SIZE)
) (
  input  wire  [`IQ_SIZE-1:0] entry_valid,
  input  wire  [`IQ_SIZE-1:0] entry_ready,

  output logic                sel_valid  [0:`IQ_DISPATCH_WIDTH-1],
  output logic [IDX_BITS-1:0] sel_index  [0:`IQ_DISPATCH_WIDTH-1],
  output logic                free_valid [0:`IQ_DISPATCH_WIDTH-1],
  output logic [IDX_BITS-1:0] free_index [0:`IQ_DISPATCH_WIDTH-1]
);

  always_comb begin
    logic [`IQ_SIZE-1:0] ready_left;
    logic [`IQ_SIZE-1:0] free_left;
    ready_left = entry_valid & entry_ready;
    free_left  = ~entry_valid;
    for (int l = 0; l < `IQ_DISPATCH_WIDTH; l++) begin
      sel_valid[l]  = 1'b0;
      sel_index[l]  = '0;
      free_valid[l] = 1'b0;
      free_index[l] = '0;
      // scan downward so the lowest index wins
      for (int e = `IQ_SIZE - 1; e >= 0; e--) begin
        if (ready_left[e]) begin
          sel_valid[l] = 1'b1;
          sel_index[l] = IDX_BITS'(e);
        end
        if (free_left[e]) begin
          free_valid[l] = 1'b1;
          free_index[l] = IDX_BITS'(e);
        end
      end
      if (sel_valid[l]) ready_left[sel_index[l]] = 1'b0;   // hide from later lanes
      if (free_valid[l]) free_left[free_index[l]] = 1'b0;
    end

    for (int i = 0; i < `IQ_DISPATCH_WIDTH; i++) begin
      for (int j = i + 1; j < `IQ_DISPATCH_WIDTH; j++) begin
        a_sel_distinct: assert (!(sel_valid[i] && sel_valid[j] && sel_index[i] == sel_index[j]))
          else $error("issue_select: lanes %0d and %0d picked the same entry", i, j);
        a_free_distinct: assert (!(free_valid[i] && free_valid[j] &&
                                   free_index[i] == free_index[j]))
          else $error("issue_select: slots %0d and %0d got the same free entry", i, j);
      end
    end
  end

endmodule

`default_nettype wire

// File: issue_queue/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_defs.svh"

module issue_queue (
  input  wire                          clk,
  input  wire                          rst_n,

  input  wire                          dispatch_en        [0:`IQ_DISPATCH_WIDTH-1],
  input  wire iq_pkg::alu_cmd_t        dispatch_alu_cmd   [0:`IQ_DISPATCH_WIDTH-1],
  input  wire                          dispatch_op1_valid [0:`IQ_DISPATCH_WIDTH-1],
  input  wire                          dispatch_op2_valid [0:`IQ_DISPATCH_WIDTH-1],
  input  wire iq_pkg::operand_t        dispatch_op1       [0:`IQ_DISPATCH_WIDTH-1],
  input  wire iq_pkg::operand_t        dispatch_op2       [0:`IQ_DISPATCH_WIDTH-1],
  input  wire [`IQ_TAG_BITS-1:0]       dispatch_phys_rd   [0:`IQ_DISPATCH_WIDTH-1],
  output logic                         full,

  input  wire                          wb_valid   [0:`IQ_DISPATCH_WIDTH-1],
  input  wire [`IQ_TAG_BITS-1:0]       wb_phys_rd [0:`IQ_DISPATCH_WIDTH-1],
  input  wire [31:0]                   wb_data    [0:`IQ_DISPATCH_WIDTH-1],

  output logic                         issue_valid   [0:`IQ_DISPATCH_WIDTH-1],
  output iq_pkg::alu_cmd_t             issue_alu_cmd [0:`IQ_DISPATCH_WIDTH-1],
  output logic [31:0]                  issue_op1     [0:`IQ_DISPATCH_WIDTH-1],
  output logic [31:0]                  issue_op2     [0:`IQ_DISPATCH_WIDTH-1],
  output logic [`IQ_TAG_BITS-1:0]      issue_phys_rd [0:`IQ_DISPATCH_WIDTH-1]
);

  localparam int W        = `IQ_DISPATCH_WIDTH;
  localparam int SIZE     = `IQ_SIZE;
  localparam int IDX_BITS = $clog2(`IQ_SIZE);

  logic [SIZE-1:0]          entry_valid;
  logic [SIZE-1:0]          entry_valid_next;
  logic [SIZE-1:0]          entry_op1_valid;
  logic [SIZE-1:0]          entry_op2_valid;
  iq_pkg::alu_cmd_t         entry_cmd     [SIZE];
  iq_pkg::operand_t         entry_op1     [SIZE];
  iq_pkg::operand_t         entry_op2     [SIZE];
  logic [`IQ_TAG_BITS-1:0]  entry_phys_rd [SIZE];

  logic [SIZE-1:0]          op1_valid_woke;
  logic [SIZE-1:0]          op2_valid_woke;
  iq_pkg::operand_t         op1_woke      [SIZE];
  iq_pkg::operand_t         op2_woke      [SIZE];
  logic                     disp_op1_valid_woke [W];
  logic                     disp_op2_valid_woke [W];
  iq_pkg::operand_t         disp_op1_woke [W];
  iq_pkg::operand_t         disp_op2_woke [W];

  logic                     sel_valid  [0:W-1];
  logic [IDX_BITS-1:0]      sel_index  [0:W-1];
  logic                     free_valid [0:W-1];
  logic [IDX_BITS-1:0]      free_index [0:W-1];
  logic                     full_next;

  // capture a writeback into a waiting operand on tag match
  function automatic void wakeup(input logic valid_in, input iq_pkg::operand_t op_in,
                                 output logic valid_out, output iq_pkg::operand_t op_out);
    valid_out = valid_in;
    op_out    = op_in;
    for (int w = 0; w < W; w++) begin
      if (!valid_in && wb_valid[w] && wb_phys_rd[w] == op_in.tag.phys) begin
        valid_out   = 1'b1;
        op_out.data = wb_data[w];
      end
    end
  endfunction

  issue_select issue_select_inst (
    .entry_valid (entry_valid),
    .entry_ready (entry_op1_valid & entry_op2_valid),
    .sel_valid,
    .sel_index,
    .free_valid,
    .free_index
  );

  always_comb begin
    for (int e = 0; e < SIZE; e++) begin
      wakeup(entry_op1_valid[e], entry_op1[e], op1_valid_woke[e], op1_woke[e]);
      wakeup(entry_op2_valid[e], entry_op2[e], op2_valid_woke[e], op2_woke[e]);
    end
    for (int s = 0; s < W; s++) begin  // same-edge capture for incoming slots
      wakeup(dispatch_op1_valid[s], dispatch_op1[s], disp_op1_valid_woke[s], disp_op1_woke[s]);
      wakeup(dispatch_op2_valid[s], dispatch_op2[s], disp_op2_valid_woke[s], disp_op2_woke[s]);
    end
  end

  always_comb begin
    entry_valid_next = entry_valid;
    for (int l = 0; l < W; l++) begin
      if (sel_valid[l]) entry_valid_next[sel_index[l]] = 1'b0;
    end
    for (int s = 0; s < W; s++) begin
      if (dispatch_en[s] && free_valid[s]) entry_valid_next[free_index[s]] = 1'b1;
    end
    full_next = $countones(entry_valid_next) > SIZE - W;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      entry_valid <= '0;
      full        <= 1'b0;
      for (int l = 0; l < W; l++) issue_valid[l] <= 1'b0;
    end else begin
      entry_valid <= entry_valid_next;
      full        <= full_next;
      for (int l = 0; l < W; l++) issue_valid[l] <= sel_valid[l];
    end
  end

  always_ff @(posedge clk) begin
    for (int e = 0; e < SIZE; e++) begin
      entry_op1_valid[e] <= op1_valid_woke[e];
      entry_op2_valid[e] <= op2_valid_woke[e];
      entry_op1[e]       <= op1_woke[e];
      entry_op2[e]       <= op2_woke[e];
    end
    for (int s = 0; s < W; s++) begin
      if (dispatch_en[s]) begin
        entry_cmd[free_index[s]]       <= dispatch_alu_cmd[s];
        entry_op1_valid[free_index[s]] <= disp_op1_valid_woke[s];
        entry_op2_valid[free_index[s]] <= disp_op2_valid_woke[s];
        entry_op1[free_index[s]]       <= disp_op1_woke[s];
        entry_op2[free_index[s]]       <= disp_op2_woke[s];
        entry_phys_rd[free_index[s]]   <= dispatch_phys_rd[s];
      end
    end
    for (int l = 0; l < W; l++) begin
      issue_alu_cmd[l] <= entry_cmd[sel_index[l]];
      issue_op1[l]     <= entry_op1[sel_index[l]].data;
      issue_op2[l]     <= entry_op2[sel_index[l]].data;
      issue_phys_rd[l] <= entry_phys_rd[sel_index[l]];
    end
  end

  for (genvar s = 0; s < W; s++) begin : g_lane_checks
    a_no_dispatch_when_full: assert property (
      @(posedge clk) disable iff (!rst_n) full |-> !dispatch_en[s])
      else $error("issue_queue: dispatch on slot %0d while full", s);

    a_issue_operands_valid: assert property (
      @(posedge clk) disable iff (!rst_n)
      sel_valid[s] |-> entry_valid[sel_index[s]] &&
                       entry_op1_valid[sel_index[s]] && entry_op2_valid[sel_index[s]])
      else $error("issue_queue: lane %0d issued with a waiting operand", s);

    for (genvar t = s + 1; t < W; t++) begin : g_pair
      a_wb_tags_distinct: assert property (
        @(posedge clk) disable iff (!rst_n)
        wb_valid[s] && wb_valid[t] |-> wb_phys_rd[s] != wb_phys_rd[t])
        else $error("issue_queue: writeback lanes %0d and %0d share a tag", s, t);
    end
  end

endmodule

`default_nettype wire

// File: logic/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_defs.svh"

module int_alu (
  input  wire                          clk,
  input  wire                          rst_n,

  input  wire                          issue_valid,
  input  wire iq_pkg::alu_cmd_t        issue_alu_cmd,
  input  wire [31:0]                   issue_op1,
  input  wire [31:0]                   issue_op2,
  input  wire [`IQ_TAG_BITS-1:0]       issue_phys_rd,

  output logic                         wb_valid,
  output logic [`IQ_TAG_BITS-1:0]      wb_phys_rd,
  output logic [31:0]                  wb_data
);

  logic [31:0] result;

  always_comb begin
    case (issue_alu_cmd)
      iq_pkg::ALU_ADD: result = issue_op1 + issue_op2;
      iq_pkg::ALU_SUB: result = issue_op1 - issue_op2;
      iq_pkg::ALU_AND: result = issue_op1 & issue_op2;
      iq_pkg::ALU_OR:  result = issue_op1 | issue_op2;
      iq_pkg::ALU_XOR: result = issue_op1 ^ issue_op2;
      iq_pkg::ALU_SLL: result = issue_op1 << issue_op2[4:0];
      iq_pkg::ALU_SRL: result = issue_op1 >> issue_op2[4:0];  // logical
      iq_pkg::ALU_SLT: result = {31'd0, $signed(issue_op1) < $signed(issue_op2)};
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) wb_valid <= 1'b0;
    else        wb_valid <= issue_valid;
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      wb_phys_rd <= issue_phys_rd;
      wb_data    <= result;
    end
  end

  a_cmd_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    issue_valid |-> issue_alu_cmd inside {iq_pkg::ALU_ADD, iq_pkg::ALU_SUB, iq_pkg::ALU_AND,
                                          iq_pkg::ALU_OR, iq_pkg::ALU_XOR, iq_pkg::ALU_SLL,
                                          iq_pkg::ALU_SRL, iq_pkg::ALU_SLT})
    else $error("int_alu: unknown command %0d issued", issue_alu_cmd);

endmodule

`default_nettype wire

// File: logic/int_backend.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_defs.svh"

module int_backend (
  input  wire                          clk,
  input  wire                          rst_n,

  input  wire                          dispatch_en        [0:`IQ_DISPATCH_WIDTH-1],
  input  wire iq_pkg::alu_cmd_t        dispatch_alu_cmd   [0:`IQ_DISPATCH_WIDTH-1],
  input  wire                          dispatch_op1_valid [0:`IQ_DISPATCH_WIDTH-1],
  input  wire                          dispatch_op2_valid [0:`IQ_DISPATCH_WIDTH-1],
  input  wire iq_pkg::operand_t        dispatch_op1       [0:`IQ_DISPATCH_WIDTH-1],
  input  wire iq_pkg::operand_t        dispatch_op2       [0:`IQ_DISPATCH_WIDTH-1],
  input  wire [`IQ_TAG_BITS-1:0]       dispatch_phys_rd   [0:`IQ_DISPATCH_WIDTH-1],
  output logic                         full,

  output logic                         wb_valid   [0:`IQ_DISPATCH_WIDTH-1],
  output logic [`IQ_TAG_BITS-1:0]      wb_phys_rd [0:`IQ_DISPATCH_WIDTH-1],
  output logic [31:0]                  wb_data    [0:`IQ_DISPATCH_WIDTH-1]
);

  logic                     issue_valid   [0:`IQ_DISPATCH_WIDTH-1];
  iq_pkg::alu_cmd_t         issue_alu_cmd [0:`IQ_DISPATCH_WIDTH-1];
  logic [31:0]              issue_op1     [0:`IQ_DISPATCH_WIDTH-1];
  logic [31:0]              issue_op2     [0:`IQ_DISPATCH_WIDTH-1];
  logic [`IQ_TAG_BITS-1:0]  issue_phys_rd [0:`IQ_DISPATCH_WIDTH-1];

  // writeback arrays loop back into the wakeup inputs
  issue_queue issue_queue_inst (
    .clk,
    .rst_n,
    .dispatch_en,
    .dispatch_alu_cmd,
    .dispatch_op1_valid,
    .dispatch_op2_valid,
    .dispatch_op1,
    .dispatch_op2,
    .dispatch_phys_rd,
    .full,
    .wb_valid,
    .wb_phys_rd,
    .wb_data,
    .issue_valid,
    .issue_alu_cmd,
    .issue_op1,
    .issue_op2,
    .issue_phys_rd
  );

  for (genvar i = 0; i < `IQ_DISPATCH_WIDTH; i++) begin : g_alu
    int_alu int_alu_inst (
      .clk,
      .rst_n,
      .issue_valid   (issue_valid[i]),
      .issue_alu_cmd (issue_alu_cmd[i]),
      .issue_op1     (issue_op1[i]),
      .issue_op2     (issue_op2[i]),
      .issue_phys_rd (issue_phys_rd[i]),
      .wb_valid      (wb_valid[i]),
      .wb_phys_rd    (wb_phys_rd[i]),
      .wb_data       (wb_data[i])
    );
  end

endmodule

`default_nettype wire

// File: tests/tb_int_backend.sv
`timescale 1ns/1ps

`include "iq_defs.svh"

module tb_int_backend;

  localparam int W            = `IQ_DISPATCH_WIDTH;
  localparam int NTAGS        = 1 << `IQ_TAG_BITS;
  localparam int CLK_PERIOD   = 4;
  localparam int RESET_CYCLES = 16;
  localparam int IDLE_CYCLES  = 8;
  localparam int MIX_CYCLES   = 600;
  localparam int BURST_CYCLES = 200;
  localparam int DRAIN_CYCLES = 200;
  localparam int LIMIT_CYCLES = RESET_CYCLES + IDLE_CYCLES + MIX_CYCLES + BURST_CYCLES +
                                DRAIN_CYCLES + 50;
  localparam int FREE = 0;
  localparam int BUSY = 1;  // dispatched, no writeback yet
  localparam int HELD = 2;  // written back, a consumer still waits on it

  logic                    clk;
  logic                    rst_n;
  logic                    dispatch_en        [0:W-1];
  iq_pkg::alu_cmd_t        dispatch_alu_cmd   [0:W-1];
  logic                    dispatch_op1_valid [0:W-1];
  logic                    dispatch_op2_valid [0:W-1];
  iq_pkg::operand_t        dispatch_op1       [0:W-1];
  iq_pkg::operand_t        dispatch_op2       [0:W-1];
  logic [`IQ_TAG_BITS-1:0] dispatch_phys_rd   [0:W-1];
  logic                    full;
  logic                    wb_valid           [0:W-1];
  logic [`IQ_TAG_BITS-1:0] wb_phys_rd         [0:W-1];
  logic [31:0]             wb_data            [0:W-1];

  // reference model, indexed by destination tag
  int               tag_state    [NTAGS];
  int               tag_readers  [NTAGS];
  int               tag_wb_cycle [NTAGS];
  logic [31:0]      tag_value    [NTAGS];
  iq_pkg::alu_cmd_t cmd_of       [NTAGS];
  bit               src_is_tag   [NTAGS][2];
  logic [31:0]      src_val      [NTAGS][2];  // value, or producer tag
  int               disp_cycle   [NTAGS];

  logic [31:0] lfsr_state;
  int          outstanding;
  int          cycle;
  int          last_tag;
  int          checks;
  int          errors;
  int          total_checks;
  int          total_errors;
  string       test_name;
  bit          saw_full;

  int_backend int_backend_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .dispatch_en        (dispatch_en),
    .dispatch_alu_cmd   (dispatch_alu_cmd),
    .dispatch_op1_valid (dispatch_op1_valid),
    .dispatch_op2_valid (dispatch_op2_valid),
    .dispatch_op1       (dispatch_op1),
    .dispatch_op2       (dispatch_op2),
    .dispatch_phys_rd   (dispatch_phys_rd),
    .full               (full),
    .wb_valid           (wb_valid),
    .wb_phys_rd         (wb_phys_rd),
    .wb_data            (wb_data)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // galois lfsr, one step per bit
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
    end
    return r;
  endfunction

  function automatic logic [31:0] alu_model(input iq_pkg::alu_cmd_t cmd,
                                            input logic [31:0] a, input logic [31:0] b);
    case (cmd)
      iq_pkg::ALU_ADD: return a + b;
      iq_pkg::ALU_SUB: return a - b;
      iq_pkg::ALU_AND: return a & b;
      iq_pkg::ALU_OR:  return a | b;
      iq_pkg::ALU_XOR: return a ^ b;
      iq_pkg::ALU_SLL: return a << b[4:0];
      iq_pkg::ALU_SRL: return a >> b[4:0];
      iq_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:         return '0;
    endcase
  endfunction

  // waiting operands carry random padding around the tag
  function automatic iq_pkg::operand_t make_operand(input bit is_tag, input logic [31:0] v);
    iq_pkg::operand_t op;
    logic [31:0]      junk;
    op.data = v;
    if (is_tag) begin
      junk        = random_bits(32 - `IQ_TAG_BITS);
      op.tag.pad  = junk[31-`IQ_TAG_BITS:0];
      op.tag.phys = v[`IQ_TAG_BITS-1:0];
    end
    return op;
  endfunction

  // random start point, then the first tag in the wanted state
  // a tag whose writeback is still on the bus stays out of the pool
  function automatic int find_tag(input int state);
    int start;
    int t;
    start = int'(random_bits(`IQ_TAG_BITS));
    for (int i = 0; i < NTAGS; i++) begin
      t = (start + i) % NTAGS;
      if (tag_state[t] == state && !(state == FREE && tag_wb_cycle[t] == cycle)) return t;
    end
    return -1;
  endfunction

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s: %s", test_name, what);
    end
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("error %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic retire(input int lane);
    int          t;
    int          src;
    logic [31:0] opv [2];
    logic [31:0] exp;
    t = int'(wb_phys_rd[lane]);
    expect_true(tag_state[t] == BUSY, $sformatf("writeback for tag %0d, not outstanding", t));
    if (tag_state[t] != BUSY) return;
    for (int k = 0; k < 2; k++) begin
      if (src_is_tag[t][k]) begin
        src = int'(src_val[t][k][`IQ_TAG_BITS-1:0]);
        expect_true(tag_state[src] != BUSY && tag_wb_cycle[src] < cycle,
                    $sformatf("tag %0d written back before its producer %0d", t, src));
        opv[k] = tag_value[src];
      end else begin
        opv[k] = src_val[t][k];
      end
    end
    expect_true(cycle - disp_cycle[t] >= 3,
                $sformatf("tag %0d written back %0d cycles after dispatch", t,
                          cycle - disp_cycle[t]));
    exp = alu_model(cmd_of[t], opv[0], opv[1]);
    compare_value($sformatf("wb_data tag %0d", t), exp, wb_data[lane]);
    tag_value[t]    = exp;
    tag_wb_cycle[t] = cycle;
    tag_state[t]    = (tag_readers[t] == 0) ? FREE : HELD;
    outstanding--;
    for (int k = 0; k < 2; k++) begin
      if (src_is_tag[t][k]) begin
        src = int'(src_val[t][k][`IQ_TAG_BITS-1:0]);
        tag_readers[src]--;
        if (tag_readers[src] == 0 && tag_state[src] == HELD) tag_state[src] = FREE;
      end
    end
  endtask

  // outputs are read 1 ns after the edge, before new inputs go out
  task automatic step_cycle();
    @(posedge clk);
    #1;
    cycle++;
    for (int l = 0; l < W; l++) begin
      if (wb_valid[l]) retire(l);
    end
    expect_true(!(full && outstanding <= `IQ_SIZE - W),
                $sformatf("full high with only %0d instructions outstanding", outstanding));
    if (full) saw_full = 1'b1;
  endtask

  task automatic drive_slot(input int s, input int go_thresh, input int dep_thresh,
                            input bit chain);
    int          rd;
    int          src;
    logic [31:0] r;
    dispatch_en[s] = 1'b0;
    if (random_bits(2) >= go_thresh) return;
    rd = find_tag(FREE);
    if (rd < 0) return;
    r = random_bits(3);
    cmd_of[rd] = iq_pkg::alu_cmd_t'(r[2:0]);
    for (int k = 0; k < 2; k++) begin
      src = -1;
      if (chain && k == 0 && last_tag >= 0 && tag_state[last_tag] == BUSY) begin
        src = last_tag;  // serial chain keeps the queue filling
      end else if (random_bits(2) < dep_thresh) begin
        src = find_tag(BUSY);
      end
      src_is_tag[rd][k] = src >= 0;
      src_val[rd][k]    = (src >= 0) ? 32'(src) : random_bits(32);
      if (src >= 0) tag_readers[src]++;
    end
    dispatch_alu_cmd[s]   = cmd_of[rd];
    dispatch_op1[s]       = make_operand(src_is_tag[rd][0], src_val[rd][0]);
    dispatch_op2[s]       = make_operand(src_is_tag[rd][1], src_val[rd][1]);
    dispatch_op1_valid[s] = !src_is_tag[rd][0];
    dispatch_op2_valid[s] = !src_is_tag[rd][1];
    dispatch_phys_rd[s]   = rd[`IQ_TAG_BITS-1:0];
    dispatch_en[s]        = 1'b1;
    tag_state[rd]  = BUSY;
    disp_cycle[rd] = cycle;
    last_tag       = rd;
    outstanding++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    checks    = 0;
    errors    = 0;
    saw_full  = 1'b0;
  endtask

  task automatic finish_test();
    $display("test %s: %0d checks, %0d errors", test_name, checks, errors);
    total_checks += checks;
    total_errors += errors;
  endtask

  task automatic run_traffic(input string name, input int n, input int go, input int dep,
                             input bit chain);
    start_test(name);
    repeat (n) begin
      step_cycle();
      for (int s = 0; s < W; s++) begin
        if (full) dispatch_en[s] = 1'b0;
        else      drive_slot(s, go, dep, chain);
      end
    end
    if (chain) expect_true(saw_full, "full never went high during the chained burst");
    finish_test();
  endtask

  initial begin
    int n;
    lfsr_state = 32'h6fcd9062;
    rst_n      = 1'b0;
    for (int s = 0; s < W; s++) begin
      dispatch_en[s]        = 1'b0;
      dispatch_alu_cmd[s]   = iq_pkg::ALU_ADD;
      dispatch_op1_valid[s] = 1'b0;
      dispatch_op2_valid[s] = 1'b0;
      dispatch_op1[s]       = '0;
      dispatch_op2[s]       = '0;
      dispatch_phys_rd[s]   = '0;
    end
    for (int t = 0; t < NTAGS; t++) begin
      tag_state[t]    = FREE;
      tag_readers[t]  = 0;
      tag_wb_cycle[t] = 0;
    end
    outstanding  = 0;
    cycle        = 0;
    last_tag     = -1;
    total_checks = 0;
    total_errors = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test("reset_idle");
    repeat (IDLE_CYCLES) begin
      step_cycle();
      for (int l = 0; l < W; l++) expect_true(!wb_valid[l], "wb_valid high before any dispatch");
      expect_true(!full, "full high before any dispatch");
    end
    finish_test();

    run_traffic("random_mix", MIX_CYCLES, 2, 1, 1'b0);   // half the slots, few dependencies
    run_traffic("burst_chains", BURST_CYCLES, 4, 2, 1'b1);

    start_test("drain");
    n = 0;
    while (outstanding > 0 && n < DRAIN_CYCLES) begin
      step_cycle();
      for (int s = 0; s < W; s++) dispatch_en[s] = 1'b0;
      n++;
    end
    expect_true(outstanding == 0,
                $sformatf("%0d instructions never written back after the drain", outstanding));
    repeat (4) step_cycle();  // stray writebacks show up in retire
    finish_test();

    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("watchdog: run still busy after %0d cycles, stopping", LIMIT_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

// File: compile.f
+incdir+common
common/iq_pkg.sv
issue_queue/issue_select.sv
issue_queue/issue_queue.sv
logic/int_alu.sv
logic/int_backend.sv
tests/tb_int_backend.sv

// File: Makefile
# Verilator build and run of the integer back end testbench
TOP := tb_int_backend

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
